// File: Makefile
TOP := tb_vector_sequencer

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -f project.f --top-module $(TOP) -Mdir obj_dir -o sim

# Output goes to the terminal, grep decides the exit status
run: compile
	./obj_dir/sim | tee /dev/stderr | grep "^No errors$$" > /dev/null

clean:
	rm -rf obj_dir

// File: project.f
seq_pkg.sv
seq_dispatch_if.sv
seq_hazard_tracker.sv
seq_unit_credits.sv
seq_issue_ctrl.sv
vector_sequencer.sv
vector_sequencer_properties.sv
tb_vector_sequencer.sv

// File: seq_dispatch_if.sv
// Dispatch bundle from the issue controller to the hazard and credit trackers
`timescale 1ns/1ps

interface seq_dispatch_if;
  import seq_pkg::*;

  // Accept strobe, high for one cycle per accepted instruction
  logic  fire;

  // ID given to the candidate
  vid_t  id;

  // Target unit of the candidate
  unit_e unit;

  // Operand registers
  vreg_t vd;
  vreg_t vs1;
  vreg_t vs2;

  // Operand use flags
  logic  use_vd;
  logic  use_vs1;
  logic  use_vs2;

  // Issue controller side
  modport ctrl (
    output fire, id, unit, vd, vs1, vs2, use_vd, use_vs1, use_vs2
  );

  // Tracker side, read only
  modport trk (
    input  fire, id, unit, vd, vs1, vs2, use_vd, use_vs1, use_vs2
  );

endinterface

// File: seq_hazard_tracker.sv
// Running-instruction set, register access lists, free-ID search and hazard vector
`timescale 1ns/1ps

module seq_hazard_tracker (
  input  logic            clk_i,
  input  logic            rst_ni,
  seq_dispatch_if.trk     disp,
  input  logic            done_valid_i,
  input  seq_pkg::vid_t   done_id_i,
  output seq_pkg::vid_t   next_id_o,
  output logic            full_o,
  output seq_pkg::vmask_t hazard_o,
  output logic            idle_o
);
  import seq_pkg::*;

  // One bit per ID still in flight
  vmask_t running_q, running_d;

  // Per register, the last reader and the last writer
  logic [NrVRegs-1:0] rd_vld_q, rd_vld_d;
  logic [NrVRegs-1:0] wr_vld_q, wr_vld_d;
  vid_t               rd_id_q [NrVRegs];
  vid_t               wr_id_q [NrVRegs];

  //////////////////////////////
  // Free ID search
  //////////////////////////////

  // Lowest clear bit of the running set wins
  always_comb begin
    next_id_o = '0;
    for (int i = NrVInsn - 1; i >= 0; i--) begin
      if (!running_q[i]) begin
        next_id_o = vid_t'(i);
      end
    end
  end

  assign full_o = &running_q;
  assign idle_o = ~|running_q;

  //////////////////////////////
  // Hazard vector
  //////////////////////////////

  always_comb begin
    hazard_o = '0;
    // RAW on the writers of the sources
    if (disp.use_vs1 && wr_vld_q[disp.vs1]) begin
      hazard_o[wr_id_q[disp.vs1]] = 1'b1;
    end
    if (disp.use_vs2 && wr_vld_q[disp.vs2]) begin
      hazard_o[wr_id_q[disp.vs2]] = 1'b1;
    end
    // WAR on the reader of the destination
    if (disp.use_vd && rd_vld_q[disp.vd]) begin
      hazard_o[rd_id_q[disp.vd]] = 1'b1;
    end
    // WAW on the writer of the destination
    if (disp.use_vd && wr_vld_q[disp.vd]) begin
      hazard_o[wr_id_q[disp.vd]] = 1'b1;
    end
  end

  //////////////////////////////
  // List and set update
  //////////////////////////////

  always_comb begin
    running_d = running_q;
    rd_vld_d  = rd_vld_q;
    wr_vld_d  = wr_vld_q;

    // Retirement drops the ID and every list entry that names it
    if (done_valid_i) begin
      running_d[done_id_i] = 1'b0;
      for (int r = 0; r < NrVRegs; r++) begin
        if (rd_vld_q[r] && rd_id_q[r] == done_id_i) begin
          rd_vld_d[r] = 1'b0;
        end
        if (wr_vld_q[r] && wr_id_q[r] == done_id_i) begin
          wr_vld_d[r] = 1'b0;
        end
      end
    end

    // New instruction takes over its entries after the clear
    if (disp.fire) begin
      running_d[disp.id] = 1'b1;
      if (disp.use_vd) wr_vld_d[disp.vd] = 1'b1;
      if (disp.use_vs1) rd_vld_d[disp.vs1] = 1'b1;
      if (disp.use_vs2) rd_vld_d[disp.vs2] = 1'b1;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      running_q <= '0;
      rd_vld_q  <= '0;
      wr_vld_q  <= '0;
    end else begin
      running_q <= running_d;
      rd_vld_q  <= rd_vld_d;
      wr_vld_q  <= wr_vld_d;
    end
  end

  // Entry IDs only matter while the matching valid bit is set
  always_ff @(posedge clk_i) begin
    if (disp.fire) begin
      if (disp.use_vd) wr_id_q[disp.vd] <= disp.id;
      if (disp.use_vs1) rd_id_q[disp.vs1] <= disp.id;
      if (disp.use_vs2) rd_id_q[disp.vs2] <= disp.id;
    end
  end

endmodule

// File: seq_issue_ctrl.sv
// Accept decision, dispatch strobe and issue register with back-pressure
`timescale 1ns/1ps

module seq_issue_ctrl (
  input  logic            clk_i,
  input  logic            rst_ni,
  seq_dispatch_if.ctrl    disp,
  // Request port
  input  logic            req_valid_i,
  input  seq_pkg::unit_e  req_unit_i,
  input  seq_pkg::vreg_t  req_vd_i,
  input  seq_pkg::vreg_t  req_vs1_i,
  input  seq_pkg::vreg_t  req_vs2_i,
  input  logic            req_use_vd_i,
  input  logic            req_use_vs1_i,
  input  logic            req_use_vs2_i,
  output logic            req_ready_o,
  // Tracker results
  input  seq_pkg::vid_t   next_id_i,
  input  logic            full_i,
  input  seq_pkg::vmask_t hazard_i,
  input  logic            unit_ready_i,
  // Issue port
  input  logic            issue_ready_i,
  output logic            issue_valid_o,
  output seq_pkg::vid_t   issue_id_o,
  output seq_pkg::unit_e  issue_unit_o,
  output seq_pkg::vmask_t issue_hazard_o
);
  import seq_pkg::*;

  // Issue register
  logic   valid_q;
  vid_t   id_q;
  unit_e  unit_q;
  vmask_t hazard_q;

  // Issue slot empty or drained this cycle
  logic   slot_free;

  // Source-less instructions wait until they are hazard free
  logic   src_ok;

  //////////////////////////////
  // Accept decision
  //////////////////////////////

  assign slot_free = !valid_q || issue_ready_i;
  assign src_ok    = req_use_vs1_i || req_use_vs2_i || hazard_i == '0;

  assign req_ready_o = slot_free && !full_i && unit_ready_i && src_ok;

  // Candidate goes to both trackers
  assign disp.fire    = req_valid_i && req_ready_o;
  assign disp.id      = next_id_i;
  assign disp.unit    = req_unit_i;
  assign disp.vd      = req_vd_i;
  assign disp.vs1     = req_vs1_i;
  assign disp.vs2     = req_vs2_i;
  assign disp.use_vd  = req_use_vd_i;
  assign disp.use_vs1 = req_use_vs1_i;
  assign disp.use_vs2 = req_use_vs2_i;

  //////////////////////////////
  // Issue register
  //////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= 1'b0;
    end else if (disp.fire) begin
      valid_q <= 1'b1;
    end else if (issue_ready_i) begin
      // Taken with nothing new behind it
      valid_q <= 1'b0;
    end
  end

  // Payload only moves on accept, so it holds under back-pressure
  always_ff @(posedge clk_i) begin
    if (disp.fire) begin
      id_q     <= next_id_i;
      unit_q   <= req_unit_i;
      hazard_q <= hazard_i;
    end
  end

  assign issue_valid_o  = valid_q;
  assign issue_id_o     = id_q;
  assign issue_unit_o   = unit_q;
  assign issue_hazard_o = hazard_q;

endmodule

// File: seq_pkg.sv
// Vector sequencer package with shared sizes, operand types and unit encoding
package seq_pkg;

  //////////////////////////////
  // Sizes
  //////////////////////////////

  // Instruction IDs that can be in flight at once
  localparam int unsigned NrVInsn = 8;

  // Architectural vector registers
  localparam int unsigned NrVRegs = 32;

  // Functional units behind the issue port
  localparam int unsigned NrUnits = 4;

  //////////////////////////////
  // Types
  //////////////////////////////

  // Vector register index
  typedef logic [$clog2(NrVRegs)-1:0] vreg_t;

  // Instruction ID
  typedef logic [$clog2(NrVInsn)-1:0] vid_t;

  // One bit per instruction ID, used for running set and hazards
  typedef logic [NrVInsn-1:0] vmask_t;

  // Target functional unit
  typedef enum logic [1:0] {
    UnitAlu   = 2'd0,
    UnitMul   = 2'd1,
    UnitLoad  = 2'd2,
    UnitStore = 2'd3
  } unit_e;

  // Queue occupancy, wide enough for a queue depth of 15
  typedef logic [3:0] cnt_t;

endpackage

// File: seq_unit_credits.sv
// Per-unit instruction queue occupancy with the unit of every ID for retirement
`timescale 1ns/1ps

module seq_unit_credits #(
  parameter int unsigned QueueDepth = 2
) (
  input  logic          clk_i,
  input  logic          rst_ni,
  seq_dispatch_if.trk   disp,
  input  logic          done_valid_i,
  input  seq_pkg::vid_t done_id_i,
  output logic          unit_ready_o
);
  import seq_pkg::*;

  // Occupancy per unit
  cnt_t  cnt_q [NrUnits];

  // Unit that each ID was sent to
  unit_e unit_tbl_q [NrVInsn];

  // Unit of the retiring ID
  unit_e done_unit;

  // Per-unit count strobes
  logic [NrUnits-1:0] cnt_up;
  logic [NrUnits-1:0] cnt_down;

  assign done_unit = unit_tbl_q[done_id_i];

  //////////////////////////////
  // Counters
  //////////////////////////////

  always_comb begin
    for (int u = 0; u < NrUnits; u++) begin
      // Count up on dispatch to this unit
      cnt_up[u]   = disp.fire && disp.unit == unit_e'(u);
      // Count down when one of its IDs retires
      cnt_down[u] = done_valid_i && done_unit == unit_e'(u);
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int u = 0; u < NrUnits; u++) begin
        cnt_q[u] <= '0;
      end
    end else begin
      for (int u = 0; u < NrUnits; u++) begin
        // Both strobes at once leave the count alone
        if (cnt_up[u] && !cnt_down[u]) begin
          cnt_q[u] <= cnt_q[u] + cnt_t'(1);
        end else if (cnt_down[u] && !cnt_up[u]) begin
          cnt_q[u] <= cnt_q[u] - cnt_t'(1);
        end
      end
    end
  end

  //////////////////////////////
  // ID to unit table
  //////////////////////////////

  // Written once per dispatch, read back on retirement
  always_ff @(posedge clk_i) begin
    if (disp.fire) begin
      unit_tbl_q[disp.id] <= disp.unit;
    end
  end

  // Room left in the candidate's queue
  assign unit_ready_o = cnt_q[disp.unit] < cnt_t'(QueueDepth);

endmodule

// File: tb_vector_sequencer.sv
// Testbench for the vector sequencer with a reference model of IDs, register lists and credits
`timescale 1ns/1ps

module tb_vector_sequencer;
  import seq_pkg::*;

  // Deeper than two so that eight running IDs leave room in every unit queue
  localparam int unsigned QueueDepth = 3;

  logic   clk_i = 1'b0;
  logic   rst_ni;
  logic   req_valid_i;
  unit_e  req_unit_i;
  vreg_t  req_vd_i, req_vs1_i, req_vs2_i;
  logic   req_use_vd_i, req_use_vs1_i, req_use_vs2_i;
  logic   req_ready_o;
  logic   issue_valid_o, issue_ready_i;
  vid_t   issue_id_o;
  unit_e  issue_unit_o;
  vmask_t issue_hazard_o;
  logic   done_valid_i;
  vid_t   done_id_i;
  logic   idle_o;

  // Model of the running set, last reader and writer per register, unit counts
  vmask_t        run_m;
  logic [31:0]   rd_vld_m, wr_vld_m;
  vid_t          rd_id_m [NrVRegs];
  vid_t          wr_id_m [NrVRegs];
  int            cnt_m [NrUnits];
  unit_e         unit_m [NrVInsn];
  // Expected issue entries {id, unit, hazard} in accept order
  logic [12:0]   exp_mem [256];
  logic [7:0]    wr_ptr = '0;
  logic [7:0]    rd_ptr = '0;
  int            errors = 0;
  int            issue_errors = 0;
  int            failed = 0;
  logic [31:0]   rng = 32'd10569;

  always #5 clk_i = ~clk_i;

  vector_sequencer #(.QueueDepth(QueueDepth)) vector_sequencer_inst (.*);

  //////////////////////////////
  // Helpers
  //////////////////////////////

  function automatic logic [31:0] xorshift32();
    rng = rng ^ (rng << 13);
    rng = rng ^ (rng >> 17);
    rng = rng ^ (rng << 5);
    return rng;
  endfunction

  function automatic int error_count();
    return errors + issue_errors;
  endfunction

  task automatic mismatch(input string name, input logic [31:0] got, input logic [31:0] exp);
    $display("Mismatch %s: got %h, expected %h", name, got, exp);
    errors++;
  endtask

  // Expected ID, hazard vector and accept decision for the request on the pins
  function automatic void predict(output vid_t id, output vmask_t hz, output logic acc);
    int i;
    i = 0;
    while (i < NrVInsn - 1 && run_m[i]) i++;
    id = vid_t'(i);
    hz = '0;
    // RAW, then WAR and WAW on the destination
    if (req_use_vs1_i && wr_vld_m[req_vs1_i]) hz[wr_id_m[req_vs1_i]] = 1'b1;
    if (req_use_vs2_i && wr_vld_m[req_vs2_i]) hz[wr_id_m[req_vs2_i]] = 1'b1;
    if (req_use_vd_i && rd_vld_m[req_vd_i]) hz[rd_id_m[req_vd_i]] = 1'b1;
    if (req_use_vd_i && wr_vld_m[req_vd_i]) hz[wr_id_m[req_vd_i]] = 1'b1;
    acc = (wr_ptr == rd_ptr || issue_ready_i) && run_m != '1 &&
          cnt_m[req_unit_i] < int'(QueueDepth) &&
          (req_use_vs1_i || req_use_vs2_i || hz == '0);
  endfunction

  task automatic model_retire(input vid_t id);
    run_m[id] = 1'b0;
    cnt_m[unit_m[id]]--;
    for (int r = 0; r < NrVRegs; r++) begin
      if (rd_id_m[r] == id) rd_vld_m[r] = 1'b0;
      if (wr_id_m[r] == id) wr_vld_m[r] = 1'b0;
    end
  endtask

  task automatic model_dispatch(input vid_t id, input vmask_t hz);
    run_m[id] = 1'b1;
    cnt_m[req_unit_i]++;
    unit_m[id] = req_unit_i;
    if (req_use_vd_i) begin
      wr_vld_m[req_vd_i] = 1'b1;
      wr_id_m[req_vd_i] = id;
    end
    if (req_use_vs1_i) begin
      rd_vld_m[req_vs1_i] = 1'b1;
      rd_id_m[req_vs1_i] = id;
    end
    if (req_use_vs2_i) begin
      rd_vld_m[req_vs2_i] = 1'b1;
      rd_id_m[req_vs2_i] = id;
    end
    exp_mem[wr_ptr] = {id, req_unit_i, hz};
    wr_ptr = wr_ptr + 8'd1;
  endtask

  // One clock with the inputs already driven and the model moved past the edge
  task automatic run_cycle(output logic acc);
    vid_t   id;
    vmask_t hz;
    logic   exp_acc;
    #1;
    predict(id, hz, exp_acc);
    if (req_ready_o !== exp_acc) mismatch("req_ready_o", 32'(req_ready_o), 32'(exp_acc));
    if (issue_valid_o !== (wr_ptr != rd_ptr)) begin
      mismatch("issue_valid_o", 32'(issue_valid_o), 32'(wr_ptr != rd_ptr));
    end
    if (idle_o !== (run_m == '0)) mismatch("idle_o", 32'(idle_o), 32'(run_m == '0));
    acc = req_valid_i && req_ready_o;
    // Retire first so a same-cycle dispatch takes over its entries
    if (done_valid_i) model_retire(done_id_i);
    if (acc) model_dispatch(id, hz);
    @(negedge clk_i);
  endtask

  task automatic present(input unit_e u, input int vd, input int vs1, input int vs2,
                         input logic [2:0] use_m);
    req_valid_i = 1'b1;
    req_unit_i = u;
    req_vd_i = vreg_t'(vd);
    req_vs1_i = vreg_t'(vs1);
    req_vs2_i = vreg_t'(vs2);
    {req_use_vd_i, req_use_vs1_i, req_use_vs2_i} = use_m;
  endtask

  // Returns the ID shown on the issue port after the accept
  task automatic wait_accept(output vid_t id);
    logic acc;
    int   n;
    acc = 1'b0;
    n = 0;
    while (!acc && n < 40) begin
      run_cycle(acc);
      n++;
    end
    req_valid_i = 1'b0;
    if (!acc) begin
      $display("Timeout: request not accepted within %0d cycles", n);
      errors++;
    end
    id = issue_id_o;
  endtask

  task automatic hold(input int cycles);
    logic acc;
    for (int c = 0; c < cycles; c++) begin
      run_cycle(acc);
      if (acc) begin
        $display("Request accepted while it should have been held");
        errors++;
      end
    end
  endtask

  task automatic retire(input vid_t id);
    logic acc;
    done_valid_i = 1'b1;
    done_id_i = id;
    run_cycle(acc);
    done_valid_i = 1'b0;
  endtask

  task automatic retire_all();
    for (int i = 0; i < NrVInsn; i++) begin
      if (run_m[i]) retire(vid_t'(i));
    end
  endtask

  task automatic wait_drain();
    logic acc;
    int   n;
    n = 0;
    while (wr_ptr != rd_ptr && n < 20) begin
      run_cycle(acc);
      n++;
    end
    if (wr_ptr != rd_ptr) begin
      $display("Timeout: issue port did not drain within %0d cycles", n);
      errors++;
    end
  endtask

  task automatic end_test(input string name, input int base);
    if (error_count() == base) begin
      $display("Test %s: pass", name);
    end else begin
      $display("Test %s: fail with %0d errors", name, error_count() - base);
      failed++;
    end
  endtask

  //////////////////////////////
  // Issue compare
  //////////////////////////////

  // Transfer sampled just after the falling edge where the inputs settle
  always begin
    logic [12:0] e;
    @(negedge clk_i);
    #2;
    if (rst_ni && issue_valid_o && issue_ready_i) begin
      if (wr_ptr == rd_ptr) begin
        $display("Issue transfer of ID %h without an accepted request", issue_id_o);
        issue_errors++;
      end else begin
        e = exp_mem[rd_ptr];
        rd_ptr = rd_ptr + 8'd1;
        if (issue_id_o !== e[12:10]) begin
          $display("Mismatch issue_id_o: got %h, expected %h", issue_id_o, e[12:10]);
          issue_errors++;
        end
        if (issue_unit_o !== e[9:8]) begin
          $display("Mismatch issue_unit_o: got %h, expected %h", issue_unit_o, e[9:8]);
          issue_errors++;
        end
        if (issue_hazard_o !== e[7:0]) begin
          $display("Mismatch issue_hazard_o: got %h, expected %h", issue_hazard_o, e[7:0]);
          issue_errors++;
        end
      end
    end
  end

  //////////////////////////////
  // Tests
  //////////////////////////////

  initial begin
    vid_t        id;
    vid_t        first_id;
    vid_t        snap_id;
    unit_e       snap_unit;
    vmask_t      snap_hz;
    logic        acc;
    logic [31:0] r;
    int          base;
    rst_ni = 1'b0;
    present(UnitAlu, 0, 0, 0, 3'b000);
    req_valid_i = 1'b0;
    issue_ready_i = 1'b1;
    done_valid_i = 1'b0;
    done_id_i = '0;
    run_m = '0;
    rd_vld_m = '0;
    wr_vld_m = '0;
    for (int i = 0; i < NrVRegs; i++) begin
      rd_id_m[i] = '0;
      wr_id_m[i] = '0;
    end
    for (int u = 0; u < NrUnits; u++) cnt_m[u] = 0;
    repeat (16) @(posedge clk_i);
    @(negedge clk_i);
    rst_ni = 1'b1;

    // Independent instructions take IDs from 0 upward
    base = error_count();
    for (int i = 0; i < 6; i++) begin
      present(unit_e'(i % 4), i, 8 + i, 16 + i, 3'b111);
      wait_accept(id);
      if (id !== vid_t'(i)) mismatch("issue_id_o", 32'(id), 32'(i));
      if (idle_o !== 1'b0) mismatch("idle_o", 32'(idle_o), 32'(0));
    end
    wait_drain();
    retire_all();
    if (idle_o !== 1'b1) mismatch("idle_o", 32'(idle_o), 32'(1));
    end_test("independent IDs", base);

    // Random dependent stream over eight registers with random retirements
    base = error_count();
    for (int c = 0; c < 300; c++) begin
      r = xorshift32();
      present(unit_e'(r[1:0]), int'(r[4:2]), int'(r[7:5]), int'(r[10:8]), r[13:11]);
      req_valid_i = r[14];
      done_valid_i = 1'b0;
      if (run_m != '0 && r[17:15] < 3'd3) begin
        id = vid_t'(r[20:18]);
        while (!run_m[id]) id = id + vid_t'(1);
        done_valid_i = 1'b1;
        done_id_i = id;
      end
      run_cycle(acc);
    end
    req_valid_i = 1'b0;
    done_valid_i = 1'b0;
    wait_drain();
    retire_all();
    end_test("random hazards", base);

    // Full unit queue blocks its own unit only
    base = error_count();
    for (int i = 0; i < QueueDepth; i++) begin
      present(UnitAlu, i, 8 + i, 16 + i, 3'b111);
      wait_accept(id);
      if (i == 0) first_id = id;
    end
    present(UnitAlu, 20, 21, 22, 3'b111);
    hold(4);
    present(UnitMul, 23, 24, 25, 3'b111);
    wait_accept(id);
    if (issue_unit_o !== UnitMul) mismatch("issue_unit_o", 32'(issue_unit_o), 32'(UnitMul));
    present(UnitAlu, 20, 21, 22, 3'b111);
    hold(2);
    retire(first_id);
    wait_accept(id);
    if (issue_unit_o !== UnitAlu) mismatch("issue_unit_o", 32'(issue_unit_o), 32'(UnitAlu));
    wait_drain();
    retire_all();
    end_test("unit credits", base);

    // Eight running IDs hold the next request until one retires
    base = error_count();
    for (int i = 0; i < NrVInsn; i++) begin
      present(unit_e'(i % 4), i, 8 + i, 16 + i, 3'b111);
      wait_accept(id);
    end
    present(UnitMul, 30, 29, 28, 3'b111);
    hold(3);
    retire(vid_t'(5));
    wait_accept(id);
    if (id !== vid_t'(5)) mismatch("issue_id_o", 32'(id), 32'(5));
    wait_drain();
    retire_all();
    end_test("full ID set", base);

    // Stalled issue port holds its payload and blocks requests
    base = error_count();
    issue_ready_i = 1'b0;
    present(UnitLoad, 1, 2, 3, 3'b111);
    wait_accept(id);
    snap_id = issue_id_o;
    snap_unit = issue_unit_o;
    snap_hz = issue_hazard_o;
    present(UnitStore, 4, 1, 5, 3'b111);
    for (int c = 0; c < 4; c++) begin
      run_cycle(acc);
      if (acc) begin
        $display("Request accepted while the issue port is stalled");
        errors++;
      end
      if (issue_id_o !== snap_id) mismatch("issue_id_o", 32'(issue_id_o), 32'(snap_id));
      if (issue_unit_o !== snap_unit) begin
        mismatch("issue_unit_o", 32'(issue_unit_o), 32'(snap_unit));
      end
      if (issue_hazard_o !== snap_hz) begin
        mismatch("issue_hazard_o", 32'(issue_hazard_o), 32'(snap_hz));
      end
    end
    issue_ready_i = 1'b1;
    wait_accept(id);
    wait_drain();
    retire_all();
    end_test("issue back-pressure", base);

    // Source-less write waits out its WAW hazard
    base = error_count();
    present(UnitAlu, 3, 10, 0, 3'b110);
    wait_accept(first_id);
    present(UnitMul, 3, 0, 0, 3'b100);
    hold(4);
    retire(first_id);
    wait_accept(id);
    if (issue_hazard_o !== '0) mismatch("issue_hazard_o", 32'(issue_hazard_o), 32'(0));
    wait_drain();
    retire_all();
    end_test("source-less hold", base);

    $display("Tests run: 6, failed: %0d, error count: %0d", failed, error_count());
    if (error_count() == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

// File: vector_sequencer.sv
// Vector instruction sequencer top with ID allocation, hazard tracking and unit credits
`timescale 1ns/1ps

module vector_sequencer #(
  parameter int unsigned QueueDepth = 2
) (
  input  logic            clk_i,
  input  logic            rst_ni,
  // Decoded instruction in
  input  logic            req_valid_i,
  input  seq_pkg::unit_e  req_unit_i,
  input  seq_pkg::vreg_t  req_vd_i,
  input  seq_pkg::vreg_t  req_vs1_i,
  input  seq_pkg::vreg_t  req_vs2_i,
  input  logic            req_use_vd_i,
  input  logic            req_use_vs1_i,
  input  logic            req_use_vs2_i,
  output logic            req_ready_o,
  // Issue to the units
  output logic            issue_valid_o,
  input  logic            issue_ready_i,
  output seq_pkg::vid_t   issue_id_o,
  output seq_pkg::unit_e  issue_unit_o,
  output seq_pkg::vmask_t issue_hazard_o,
  // Completions
  input  logic            done_valid_i,
  input  seq_pkg::vid_t   done_id_i,
  output logic            idle_o
);
  import seq_pkg::*;

  // Tracker results into the controller
  vid_t   next_id;
  logic   full;
  vmask_t hazard;
  logic   unit_ready;

  // Candidate and accept strobe
  seq_dispatch_if disp ();

  seq_hazard_tracker hazard_tracker_inst (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .disp         (disp.trk),
    .done_valid_i (done_valid_i),
    .done_id_i    (done_id_i),
    .next_id_o    (next_id),
    .full_o       (full),
    .hazard_o     (hazard),
    .idle_o       (idle_o)
  );

  seq_unit_credits #(
    .QueueDepth (QueueDepth)
  ) unit_credits_inst (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .disp         (disp.trk),
    .done_valid_i (done_valid_i),
    .done_id_i    (done_id_i),
    .unit_ready_o (unit_ready)
  );

  seq_issue_ctrl issue_ctrl_inst (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .disp           (disp.ctrl),
    .req_valid_i    (req_valid_i),
    .req_unit_i     (req_unit_i),
    .req_vd_i       (req_vd_i),
    .req_vs1_i      (req_vs1_i),
    .req_vs2_i      (req_vs2_i),
    .req_use_vd_i   (req_use_vd_i),
    .req_use_vs1_i  (req_use_vs1_i),
    .req_use_vs2_i  (req_use_vs2_i),
    .req_ready_o    (req_ready_o),
    .next_id_i      (next_id),
    .full_i         (full),
    .hazard_i       (hazard),
    .unit_ready_i   (unit_ready),
    .issue_ready_i  (issue_ready_i),
    .issue_valid_o  (issue_valid_o),
    .issue_id_o     (issue_id_o),
    .issue_unit_o   (issue_unit_o),
    .issue_hazard_o (issue_hazard_o)
  );

endmodule

// File: vector_sequencer_properties.sv
// Issue-port and request handshake assertions bound to the sequencer top
`timescale 1ns/1ps

module vector_sequencer_properties (
  input logic            clk_i,
  input logic            rst_ni,
  input logic            req_ready_o,
  input logic            issue_valid_o,
  input logic            issue_ready_i,
  input seq_pkg::vid_t   issue_id_o,
  input seq_pkg::unit_e  issue_unit_o,
  input seq_pkg::vmask_t issue_hazard_o
);

  // Pending issue keeps its payload until taken
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    issue_valid_o && !issue_ready_i |=> issue_valid_o && $stable(issue_id_o) &&
      $stable(issue_unit_o) && $stable(issue_hazard_o))
  else $error("issue outputs changed while the port was stalled");

  // No new request while the slot is blocked
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    issue_valid_o && !issue_ready_i |-> !req_ready_o)
  else $error("req_ready_o high with a stalled issue pending");

  // Issue register empty in reset
  assert property (@(posedge clk_i) !rst_ni |-> !issue_valid_o)
  else $error("issue_valid_o high during reset");

endmodule

bind vector_sequencer vector_sequencer_properties vector_sequencer_properties_inst (
  .clk_i          (clk_i),
  .rst_ni         (rst_ni),
  .req_ready_o    (req_ready_o),
  .issue_valid_o  (issue_valid_o),
  .issue_ready_i  (issue_ready_i),
  .issue_id_o     (issue_id_o),
  .issue_unit_o   (issue_unit_o),
  .issue_hazard_o (issue_hazard_o)
);
